// File: sources.f
+incdir+verification
src/bp_pkg.sv
src/resolve_if.sv
src/branch_target_buffer.sv
src/agree_pht.sv
src/next_pc_sel.sv
src/agree_bp_top.sv
verification/tb_agree_bp.sv

// File: src/agree_bp_top.sv
`timescale 1ns/100ps

module agree_bp_top #(
    parameter int INDEX_WIDTH   = 6,
    parameter int HISTORY_WIDTH = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  bp_pkg::addr_t            fetch_pc_i,

    // Resolution of an older branch, one-cycle strobe
    input  logic                     res_valid_i,
    input  bp_pkg::addr_t            res_pc_i,
    input  bp_pkg::addr_t            res_target_i,
    input  logic                     res_taken_i,
    input  logic                     res_pred_i,
    input  logic                     res_btb_hit_i,
    input  logic [HISTORY_WIDTH-1:0] res_ghr_i,
    input  logic                     res_bias_i,

    output bp_pkg::addr_t            next_pc_o,
    output logic                     pred_taken_o,
    output logic                     btb_hit_o,
    output logic                     bias_o,
    output logic [HISTORY_WIDTH-1:0] ghr_o,
    output logic                     flush_o
);
    import bp_pkg::*;

    addr_t btb_target;
    logic  agree;

    resolve_if #(
        .HISTORY_WIDTH (HISTORY_WIDTH)
    ) res_bus ();

    assign res_bus.valid   = res_valid_i;
    assign res_bus.pc      = res_pc_i;
    assign res_bus.target  = res_target_i;
    assign res_bus.taken   = res_taken_i;
    assign res_bus.pred    = res_pred_i;
    assign res_bus.btb_hit = res_btb_hit_i;
    assign res_bus.ghr     = res_ghr_i;
    assign res_bus.bias    = res_bias_i;

    branch_target_buffer #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_btb (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .fetch_pc_i (fetch_pc_i),
        .res_i      (res_bus.btb_mp),
        .hit_o      (btb_hit_o),
        .target_o   (btb_target),
        .bias_o     (bias_o)
    );

    agree_pht #(
        .HISTORY_WIDTH (HISTORY_WIDTH)
    ) u_pht (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .fetch_pc_i (fetch_pc_i),
        .res_i      (res_bus.pht_mp),
        .agree_o    (agree),
        .ghr_o      (ghr_o)
    );

    // Lookup results combine with the resolution in the same cycle
    next_pc_sel u_sel (
        .fetch_pc_i   (fetch_pc_i),
        .hit_i        (btb_hit_o),
        .bias_i       (bias_o),
        .agree_i      (agree),
        .btb_target_i (btb_target),
        .res_i        (res_bus.sel_mp),
        .next_pc_o    (next_pc_o),
        .pred_taken_o (pred_taken_o),
        .flush_o      (flush_o)
    );

endmodule

// File: src/agree_pht.sv
`timescale 1ns/100ps

module agree_pht #(
    parameter int HISTORY_WIDTH = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  bp_pkg::addr_t            fetch_pc_i,
    resolve_if.pht_mp                res_i,
    output logic                     agree_o,
    output logic [HISTORY_WIDTH-1:0] ghr_o
);
    import bp_pkg::*;

    localparam int PHT_ENTRIES = 2 ** HISTORY_WIDTH;

    typedef logic [HISTORY_WIDTH-1:0] hist_t;

    hist_t    ghr_q;
    counter_t cnt_q [PHT_ENTRIES];

    hist_t    rd_idx;
    hist_t    wr_idx;
    logic     train;
    logic     agreed;
    counter_t cnt_cur;
    counter_t cnt_next;

    // Gshare-style index, low PC word bits folded with history
    assign rd_idx  = fetch_pc_i[HISTORY_WIDTH+1:2] ^ ghr_q;
    assign agree_o = cnt_q[rd_idx][1];
    assign ghr_o   = ghr_q;

    // Training uses the history seen at fetch, not the current one
    assign wr_idx  = res_i.pc[HISTORY_WIDTH+1:2] ^ res_i.ghr;
    assign train   = res_i.valid && res_i.btb_hit;
    assign agreed  = (res_i.taken == res_i.bias);
    assign cnt_cur = cnt_q[wr_idx];

    // Saturating up on agreement, down otherwise
    always_comb begin
        cnt_next = cnt_cur;
        if (agreed) begin
            if (cnt_cur != CNT_MAX) begin
                cnt_next = counter_t'(cnt_cur + 2'd1);
            end
        end else begin
            if (cnt_cur != CNT_MIN) begin
                cnt_next = counter_t'(cnt_cur - 2'd1);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                cnt_q[i] <= CNT_RESET;
            end
        end else if (train) begin
            cnt_q[wr_idx] <= cnt_next;
        end
    end

    // Actual outcomes only, newest in bit 0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_q <= '0;
        end else if (res_i.valid) begin
            ghr_q <= {ghr_q[HISTORY_WIDTH-2:0], res_i.taken};
        end
    end

    // History is never updated speculatively
    a_ghr_on_resolve: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !$stable(ghr_q) |-> $past(res_i.valid)
    ) else $error("GHR changed without a resolved branch");

endmodule

// File: src/bp_pkg.sv
package bp_pkg;

    // Fetch and target address width, also the instruction width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;

    // One agree counter, upper bit set means agree with the BTB bias
    typedef logic [1:0] counter_t;

    // Weakly agree, the state every counter starts in
    localparam counter_t CNT_RESET = 2'b10;

    // Saturation limits
    localparam counter_t CNT_MAX = 2'b11;
    localparam counter_t CNT_MIN = 2'b00;

    // Byte offset of the next sequential instruction
    localparam addr_t PC_STEP = 32'd4;

endpackage

// File: src/branch_target_buffer.sv
`timescale 1ns/100ps

module branch_target_buffer #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  bp_pkg::addr_t       fetch_pc_i,
    resolve_if.btb_mp           res_i,
    output logic                hit_o,
    output bp_pkg::addr_t       target_o,
    output logic                bias_o
);
    import bp_pkg::*;

    localparam int BTB_ENTRIES = 2 ** INDEX_WIDTH;
    localparam int TAG_WIDTH   = XLEN - INDEX_WIDTH - 2;

    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0]   tag_t;

    // Entry storage
    logic [BTB_ENTRIES-1:0] valid_q;
    logic [BTB_ENTRIES-1:0] bias_q;
    tag_t                   tag_q    [BTB_ENTRIES];
    addr_t                  target_q [BTB_ENTRIES];

    // Lookup side
    index_t rd_idx;
    tag_t   rd_tag;

    // Update side
    index_t wr_idx;
    tag_t   wr_tag;
    logic   alloc;
    logic   refresh;

    // Word-aligned PC, index above the byte offset, tag above the index
    assign rd_idx = fetch_pc_i[INDEX_WIDTH+1:2];
    assign rd_tag = fetch_pc_i[XLEN-1:INDEX_WIDTH+2];

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    // Bias only means something for a matching entry
    assign bias_o = hit_o && bias_q[rd_idx];

    assign wr_idx = res_i.pc[INDEX_WIDTH+1:2];
    assign wr_tag = res_i.pc[XLEN-1:INDEX_WIDTH+2];

    // Miss at fetch allocates, taken hit refreshes the target
    assign alloc   = res_i.valid && !res_i.btb_hit;
    assign refresh = res_i.valid && res_i.btb_hit && res_i.taken;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (alloc) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= res_i.target;
            // First outcome becomes the static bias of the entry
            bias_q[wr_idx]   <= res_i.taken;
        end else if (refresh) begin
            target_q[wr_idx] <= res_i.target;
        end
    end

    // Lookup must resolve cleanly once reset is released
    a_hit_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !$isunknown(fetch_pc_i) |-> !$isunknown(hit_o)
    ) else $error("BTB hit is unknown for a known fetch PC");

endmodule

// File: src/next_pc_sel.sv
`timescale 1ns/100ps

module next_pc_sel (
    input  bp_pkg::addr_t fetch_pc_i,
    input  logic          hit_i,
    input  logic          bias_i,
    input  logic          agree_i,
    input  bp_pkg::addr_t btb_target_i,
    resolve_if.sel_mp     res_i,
    output bp_pkg::addr_t next_pc_o,
    output logic          pred_taken_o,
    output logic          flush_o
);
    import bp_pkg::*;

    logic  mispredict;
    addr_t fetch_seq_pc;
    addr_t res_seq_pc;

    // Agree keeps the bias, disagree inverts it; no hit means not taken
    assign pred_taken_o = hit_i && (agree_i ? bias_i : !bias_i);

    // Older branch resolved against its fetch-time prediction
    assign mispredict = res_i.valid && (res_i.taken != res_i.pred);
    assign flush_o    = mispredict;

    assign fetch_seq_pc = fetch_pc_i + PC_STEP;
    assign res_seq_pc   = res_i.pc + PC_STEP;

    // Redirect from resolution wins over the current prediction
    always_comb begin
        if (mispredict && res_i.taken) begin
            next_pc_o = res_i.target;
        end else if (mispredict) begin
            next_pc_o = res_seq_pc;
        end else if (pred_taken_o) begin
            next_pc_o = btb_target_i;
        end else begin
            next_pc_o = fetch_seq_pc;
        end
    end

endmodule

// File: src/resolve_if.sv
`timescale 1ns/100ps

interface resolve_if #(
    parameter int HISTORY_WIDTH = 4
);
    import bp_pkg::*;

    // One-cycle strobe, a branch or jump resolved this cycle
    logic                     valid;
    addr_t                    pc;
    addr_t                    target;
    logic                     taken;

    // State captured when the branch was fetched
    logic                     pred;
    logic                     btb_hit;
    logic [HISTORY_WIDTH-1:0] ghr;
    logic                     bias;

    modport btb_mp (input valid, input pc, input target, input taken, input btb_hit);

    modport pht_mp (input valid, input pc, input taken, input btb_hit, input ghr,
                    input bias);

    modport sel_mp (input valid, input pc, input target, input taken, input pred);

endinterface

// File: verification/bp_ref_model.svh
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

// Mirror of the BTB, the agree counters and the GHR
logic     ref_valid  [2**INDEX_WIDTH];
addr_t    ref_tag    [2**INDEX_WIDTH];
addr_t    ref_target [2**INDEX_WIDTH];
logic     ref_bias   [2**INDEX_WIDTH];
counter_t ref_cnt    [2**HISTORY_WIDTH];
hist_t    ref_ghr;

// 16-bit Fibonacci LFSR, taps 16 14 13 11
logic [15:0] lfsr_q = 16'd90;

function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_step()};
    end
    return r;
endfunction

function automatic void reset_model();
    for (int i = 0; i < 2**INDEX_WIDTH; i++) begin
        ref_valid[i] = 1'b0;
    end
    for (int i = 0; i < 2**HISTORY_WIDTH; i++) begin
        ref_cnt[i] = CNT_RESET;
    end
    ref_ghr = '0;
endfunction

// Expected combinational outputs for the inputs of this cycle
function automatic void predict_outputs(
    input  addr_t fetch_pc,
    input  logic  v,
    input  addr_t pc,
    input  addr_t tgt,
    input  logic  taken,
    input  logic  pred,
    output addr_t exp_next,
    output logic  exp_pred,
    output logic  exp_flush,
    output logic  exp_hit,
    output logic  exp_bias
);
    int   bi;
    int   pi;
    logic agree;
    bi = fetch_pc[INDEX_WIDTH+1:2];
    pi = fetch_pc[HISTORY_WIDTH+1:2] ^ ref_ghr;
    agree = ref_cnt[pi][1];
    exp_hit = ref_valid[bi] && (ref_tag[bi] == (fetch_pc >> (INDEX_WIDTH + 2)));
    exp_bias = exp_hit && ref_bias[bi];
    exp_pred = exp_hit && (agree ? ref_bias[bi] : !ref_bias[bi]);
    exp_flush = v && (taken != pred);
    if (exp_flush && taken) begin
        exp_next = tgt;
    end else if (exp_flush) begin
        exp_next = pc + 32'd4;
    end else if (exp_pred) begin
        exp_next = ref_target[bi];
    end else begin
        exp_next = fetch_pc + 32'd4;
    end
endfunction

// State change at the coming clock edge
function automatic void apply_resolution(
    input addr_t pc,
    input addr_t tgt,
    input logic  taken,
    input logic  hit,
    input hist_t ghr,
    input logic  bias
);
    int bi;
    int pi;
    bi = pc[INDEX_WIDTH+1:2];
    pi = pc[HISTORY_WIDTH+1:2] ^ ghr;
    if (!hit) begin
        ref_valid[bi]  = 1'b1;
        ref_tag[bi]    = pc >> (INDEX_WIDTH + 2);
        ref_target[bi] = tgt;
        ref_bias[bi]   = taken;
    end else begin
        if (taken) begin
            ref_target[bi] = tgt;
        end
        // Saturating agree counter
        if (taken == bias) begin
            if (ref_cnt[pi] != 2'b11) ref_cnt[pi] = ref_cnt[pi] + 2'd1;
        end else begin
            if (ref_cnt[pi] != 2'b00) ref_cnt[pi] = ref_cnt[pi] - 2'd1;
        end
    end
    ref_ghr = {ref_ghr[HISTORY_WIDTH-2:0], taken};
endfunction

`endif

// File: verification/tb_agree_bp.sv
`timescale 1ns/100ps

module tb_agree_bp;
    import bp_pkg::*;

    localparam int INDEX_WIDTH     = 6;
    localparam int HISTORY_WIDTH   = 4;
    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 30;
    localparam int N_RANDOM        = 400;
    localparam int MARGIN_CYCLES   = 50;

    typedef logic [HISTORY_WIDTH-1:0] hist_t;

    logic  clk_i;
    logic  rst_ni;
    addr_t fetch_pc_i;
    logic  res_valid_i;
    addr_t res_pc_i;
    addr_t res_target_i;
    logic  res_taken_i;
    logic  res_pred_i;
    logic  res_btb_hit_i;
    hist_t res_ghr_i;
    logic  res_bias_i;
    addr_t next_pc_o;
    logic  pred_taken_o;
    logic  btb_hit_o;
    logic  bias_o;
    hist_t ghr_o;
    logic  flush_o;
    int    err_count = 0;

    // Resolution PCs share a few BTB indices but differ in tag
    addr_t pc_pool [8] = '{32'h0000_0100, 32'h0000_1100, 32'h0000_2104, 32'h0000_0104,
                           32'h0001_0100, 32'h0000_3108, 32'h0000_0108, 32'h0000_1104};

    `include "bp_ref_model.svh"

    agree_bp_top u_agree_bp_top (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_pc_i    (fetch_pc_i),
        .res_valid_i   (res_valid_i),
        .res_pc_i      (res_pc_i),
        .res_target_i  (res_target_i),
        .res_taken_i   (res_taken_i),
        .res_pred_i    (res_pred_i),
        .res_btb_hit_i (res_btb_hit_i),
        .res_ghr_i     (res_ghr_i),
        .res_bias_i    (res_bias_i),
        .next_pc_o     (next_pc_o),
        .pred_taken_o  (pred_taken_o),
        .btb_hit_o     (btb_hit_o),
        .bias_o        (bias_o),
        .ghr_o         (ghr_o),
        .flush_o       (flush_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            err_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic compare_ghr(input string name, input hist_t got, input hist_t exp);
        if (got !== exp) begin
            err_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // All inputs change on the falling edge
    task automatic drive_inputs(input addr_t fetch, input logic v, input addr_t pc,
                                input addr_t tgt, input logic taken, input logic pred,
                                input logic hit, input hist_t ghr, input logic bias);
        @(negedge clk_i);
        fetch_pc_i    = fetch;
        res_valid_i   = v;
        res_pc_i      = pc;
        res_target_i  = tgt;
        res_taken_i   = taken;
        res_pred_i    = pred;
        res_btb_hit_i = hit;
        res_ghr_i     = ghr;
        res_bias_i    = bias;
    endtask

    task automatic drive_fetch(input addr_t fetch);
        drive_inputs(fetch, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic wait_settle();
        #(CLK_PERIOD/4);
    endtask

    // Checks every cycle against the model, then steps the model
    initial begin : compare_outputs
        addr_t exp_next;
        logic  exp_pred;
        logic  exp_flush;
        logic  exp_hit;
        logic  exp_bias;
        forever begin
            @(negedge clk_i);
            #(CLK_PERIOD/4);
            if (rst_ni) begin
                predict_outputs(fetch_pc_i, res_valid_i, res_pc_i, res_target_i, res_taken_i,
                                res_pred_i, exp_next, exp_pred, exp_flush, exp_hit, exp_bias);
                compare_addr("next_pc_o", next_pc_o, exp_next);
                compare_bit("pred_taken_o", pred_taken_o, exp_pred);
                compare_bit("flush_o", flush_o, exp_flush);
                compare_bit("btb_hit_o", btb_hit_o, exp_hit);
                compare_bit("bias_o", bias_o, exp_bias);
                compare_ghr("ghr_o", ghr_o, ref_ghr);
                if (res_valid_i) begin
                    apply_resolution(res_pc_i, res_target_i, res_taken_i, res_btb_hit_i,
                                     res_ghr_i, res_bias_i);
                end
            end
        end
    end

    initial begin : watchdog
        #((RESET_CYCLES + DIRECTED_CYCLES + N_RANDOM + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("TEST FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin : stimulus
        addr_t br_pc;
        addr_t br_tgt;
        logic  bits [4];
        reset_model();
        rst_ni        = 1'b0;
        fetch_pc_i    = '0;
        res_valid_i   = 1'b0;
        res_pc_i      = '0;
        res_target_i  = '0;
        res_taken_i   = 1'b0;
        res_pred_i    = 1'b0;
        res_btb_hit_i = 1'b0;
        res_ghr_i     = '0;
        res_bias_i    = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;

        // Empty predictor falls through
        for (int i = 0; i < 8; i++) begin
            drive_fetch(32'h0000_1000 + 32'(i * 4));
            wait_settle();
            compare_addr("next_pc_o", next_pc_o, 32'h0000_1004 + 32'(i * 4));
            compare_bit("pred_taken_o", pred_taken_o, 1'b0);
            compare_bit("btb_hit_o", btb_hit_o, 1'b0);
            compare_bit("flush_o", flush_o, 1'b0);
        end

        // Taken miss allocates with bias set
        br_pc  = 32'h0000_2040;
        br_tgt = 32'h0000_3000;
        drive_inputs(32'h100, 1'b1, br_pc, br_tgt, 1'b1, 1'b0, 1'b0, 4'h0, 1'b0);
        wait_settle();
        compare_bit("flush_o", flush_o, 1'b1);
        compare_addr("next_pc_o", next_pc_o, br_tgt);
        drive_fetch(br_pc);
        wait_settle();
        compare_bit("btb_hit_o", btb_hit_o, 1'b1);
        compare_bit("bias_o", bias_o, 1'b1);
        compare_bit("pred_taken_o", pred_taken_o, 1'b1);
        compare_addr("next_pc_o", next_pc_o, br_tgt);

        // Predicted taken, resolved not taken
        drive_inputs(32'h200, 1'b1, 32'h4000, 32'h5000, 1'b0, 1'b1, 1'b0, 4'h1, 1'b0);
        wait_settle();
        compare_bit("flush_o", flush_o, 1'b1);
        compare_addr("next_pc_o", next_pc_o, 32'h0000_4004);

        // Two disagreements at the index the final fetch will use
        repeat (2) begin
            drive_inputs(br_pc, 1'b1, br_pc, br_tgt, 1'b0, 1'b1, 1'b1, 4'h8, 1'b1);
        end
        drive_fetch(br_pc);
        wait_settle();
        compare_bit("btb_hit_o", btb_hit_o, 1'b1);
        compare_bit("pred_taken_o", pred_taken_o, 1'b0);
        compare_addr("next_pc_o", next_pc_o, br_pc + 32'd4);

        // History takes outcomes newest first in bit 0
        bits = '{1'b1, 1'b0, 1'b1, 1'b1};
        for (int i = 0; i < 4; i++) begin
            drive_inputs(32'h300, 1'b1, 32'h6000, 32'h7000, bits[i], bits[i], 1'b0, 4'h0,
                         1'b0);
        end
        drive_fetch(32'h300);
        wait_settle();
        compare_ghr("ghr_o", ghr_o, 4'b1011);

        // Random fetches and resolutions
        for (int n = 0; n < N_RANDOM; n++) begin
            if (lfsr_step()) begin
                br_pc = pc_pool[rand_bits(3)];
            end else begin
                br_pc = {rand_bits(30), 2'b00};
            end
            drive_inputs(br_pc, lfsr_step(), pc_pool[rand_bits(3)], {rand_bits(30), 2'b00},
                         lfsr_step(), lfsr_step(), lfsr_step(), hist_t'(rand_bits(4)),
                         lfsr_step());
        end
        drive_fetch(32'h0);
        #(CLK_PERIOD/2);

        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
